// File: hdl/axil_bus_pkg.sv
/* Bus widths and payload types shared by the AXI-lite slave side and the
   Wishbone master side of the write bridge */

package axil_bus_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// AXI byte address
	localparam int AXI_ADDR_W = 28;
	localparam int DATA_W     = 32;
	localparam int SEL_W      = DATA_W / 8;

	// Byte offset bits that Wishbone does not see
	localparam int ADDR_LSBS  = 2;
	localparam int WB_ADDR_W  = AXI_ADDR_W - ADDR_LSBS;

	////////////////////////////////////////////////////////////
	// Payload types
	////////////////////////////////////////////////////////////

	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [SEL_W-1:0]     sel_t;

	// Write data in the upper bits, byte select in the lower bits
	typedef logic [DATA_W+SEL_W-1:0] wr_data_t;

endpackage

// File: hdl/wr_track_pkg.sv
/* Depth, pointer types and B response codes for the record of writes
   in flight between AXI acceptance and the B channel */

package wr_track_pkg;

	// Record holds up to eight writes
	localparam int LGFIFO     = 3;
	localparam int FIFO_DEPTH = 1 << LGFIFO;

	// Extra top bit tells a full record from an empty one
	typedef logic [LGFIFO:0] ptr_t;

	// Acks still owed by the Wishbone slave, 0 to FIFO_DEPTH
	typedef logic [LGFIFO:0] cnt_t;

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

endpackage

// File: hdl/axil_hold_slot.sv
/* One-entry holding register for a channel payload that could not be used
   in its arrival cycle. The pairing stage keeps one per AXI channel */
`timescale 1ns/1ps

module axil_hold_slot
	import axil_bus_pkg::*;
#(
	parameter type T_PAYLOAD = wb_addr_t
)
(
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_load,
	input  T_PAYLOAD i_payload,
	input  logic     i_clear,
	output logic     o_valid,
	output T_PAYLOAD o_payload
);

	logic w_reset;

	assign w_reset = i_reset;

	// Clear wins, the entry was consumed this cycle
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			o_valid <= 1'b0;
		else if (i_clear)
			o_valid <= 1'b0;
		else if (i_load)
			o_valid <= 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_load)
			o_payload <= i_payload;
	end

	// The channel ready stays low while the entry is occupied
	a_no_overwrite: assert property (@(posedge i_clk) disable iff (w_reset)
		i_load |-> !o_valid);

endmodule

// File: hdl/axil_wr_pair.sv
/* Pairing stage. Joins each AXI-lite write address with its write data,
   parks whichever half comes first and pulses accept for a complete write */
`timescale 1ns/1ps

module axil_wr_pair
	import axil_bus_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_axi_awvalid,
	input  logic [AXI_ADDR_W-1:0] i_axi_awaddr,
	input  logic                  i_axi_wvalid,
	input  data_t                 i_axi_wdata,
	input  sel_t                  i_axi_wstrb,
	input  logic                  i_issue_busy,
	input  logic                  i_full,
	input  logic                  i_err_state,
	output logic                  o_axi_awready,
	output logic                  o_axi_wready,
	output logic                  o_accept,
	output wb_addr_t              o_acc_addr,
	output wr_data_t              o_acc_data
);

	logic     w_reset;
	logic     w_blocked;
	logic     w_aw_hs;
	logic     w_w_hs;
	logic     w_aw_held;
	logic     w_w_held;
	wb_addr_t w_aw_live;
	wr_data_t w_w_live;
	wb_addr_t w_aw_slot;
	wr_data_t w_w_slot;

	assign w_reset = i_reset;

	// Word address as Wishbone sees it
	assign w_aw_live = i_axi_awaddr[AXI_ADDR_W-1:ADDR_LSBS];
	assign w_w_live  = {i_axi_wdata, i_axi_wstrb};

	// Stalled request, full record or error drain
	assign w_blocked = i_issue_busy || i_full || i_err_state;

	assign o_axi_awready = !w_aw_held && !w_blocked;
	assign o_axi_wready  = !w_w_held && !w_blocked;

	assign w_aw_hs = i_axi_awvalid && o_axi_awready;
	assign w_w_hs  = i_axi_wvalid && o_axi_wready;

	assign o_accept = (w_aw_held || w_aw_hs) && (w_w_held || w_w_hs) && !w_blocked;

	// A held half is older than anything on the live bus
	assign o_acc_addr = w_aw_held ? w_aw_slot : w_aw_live;
	assign o_acc_data = w_w_held ? w_w_slot : w_w_live;

	////////////////////////////////////////////////////////////
	// Hold slots
	////////////////////////////////////////////////////////////

	axil_hold_slot #(
		.T_PAYLOAD(wb_addr_t)
	) u_aw_slot (
		.i_clk     (i_clk),
		.i_reset   (w_reset),
		.i_load    (w_aw_hs && !o_accept),
		.i_payload (w_aw_live),
		.i_clear   (o_accept),
		.o_valid   (w_aw_held),
		.o_payload (w_aw_slot)
	);

	axil_hold_slot #(
		.T_PAYLOAD(wr_data_t)
	) u_w_slot (
		.i_clk     (i_clk),
		.i_reset   (w_reset),
		.i_load    (w_w_hs && !o_accept),
		.i_payload (w_w_live),
		.i_clear   (o_accept),
		.o_valid   (w_w_held),
		.o_payload (w_w_slot)
	);

	// The tracker record must never be pushed past its depth
	a_no_accept_full: assert property (@(posedge i_clk) disable iff (w_reset)
		o_accept |-> !i_full);

endmodule

// File: hdl/wb_wr_issue.sv
/* Issue stage. Drives the pipelined Wishbone write requests and keeps the
   cycle open while any acknowledgement is still owed */
`timescale 1ns/1ps

module wb_wr_issue
	import axil_bus_pkg::*;
	import wr_track_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_accept,
	input  wb_addr_t i_acc_addr,
	input  wr_data_t i_acc_data,
	input  logic     i_wb_ack,
	input  logic     i_wb_stall,
	input  logic     i_wb_err,
	input  logic     i_err_state,
	output logic     o_wb_cyc,
	output logic     o_wb_stb,
	output wb_addr_t o_wb_addr,
	output data_t    o_wb_data,
	output sel_t     o_wb_sel,
	output logic     o_issue_busy,
	output logic     o_wb_done,
	output logic     o_wb_err
);

	logic w_reset;
	logic w_req_taken;
	cnt_t r_outstanding;

	assign w_reset = i_reset;

	assign o_issue_busy = o_wb_stb && i_wb_stall;
	assign w_req_taken  = o_wb_stb && !i_wb_stall;

	// Replies only count inside the cycle
	assign o_wb_done = o_wb_cyc && (i_wb_ack || i_wb_err);
	assign o_wb_err  = o_wb_cyc && i_wb_err;

	assign o_wb_cyc = o_wb_stb || (r_outstanding != '0);

	////////////////////////////////////////////////////////////
	// Request
	////////////////////////////////////////////////////////////

	// A bus error drops the whole cycle
	always_ff @(posedge i_clk)
	begin
		if (w_reset || o_wb_err || i_err_state)
			o_wb_stb <= 1'b0;
		else if (i_accept)
			o_wb_stb <= 1'b1;
		else if (!i_wb_stall)
			o_wb_stb <= 1'b0;
	end

	// Frozen while the slave stalls
	always_ff @(posedge i_clk)
	begin
		if (!o_issue_busy)
		begin
			o_wb_addr <= i_acc_addr;
			o_wb_data <= i_acc_data[DATA_W+SEL_W-1:SEL_W];
			o_wb_sel  <= i_acc_data[SEL_W-1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Outstanding acks
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (w_reset || !o_wb_cyc || o_wb_err || i_err_state)
			r_outstanding <= '0;
		else if (w_req_taken && !i_wb_ack)
			r_outstanding <= r_outstanding + 1'b1;
		else if (!w_req_taken && i_wb_ack)
			r_outstanding <= r_outstanding - 1'b1;
	end

	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (w_reset)
		o_wb_stb |-> o_wb_cyc);

	// Bounded by the tracker's full flag on the AXI side
	a_outstanding_max: assert property (@(posedge i_clk) disable iff (w_reset)
		r_outstanding <= cnt_t'(FIFO_DEPTH));

endmodule

// File: hdl/wr_resp_tracker.sv
/* Response stage. Keeps the ordered record of writes in flight and returns
   one B response per accepted write, including the drain after a bus error */
`timescale 1ns/1ps

module wr_resp_tracker
	import wr_track_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_reset,
	input  logic  i_accept,
	input  logic  i_wb_done,
	input  logic  i_wb_err,
	input  logic  i_axi_bready,
	output logic  o_axi_bvalid,
	output resp_t o_axi_bresp,
	output logic  o_full,
	output logic  o_err_state
);

	logic  w_reset;
	logic  w_b_taken;
	ptr_t  r_first;
	ptr_t  r_mid;
	ptr_t  r_last;
	ptr_t  r_err_loc;
	ptr_t  w_next_first;
	ptr_t  w_last_inc;
	ptr_t  w_next_last;
	ptr_t  w_fill;
	ptr_t  w_next_fill;
	ptr_t  w_resp_slot;
	ptr_t  w_err_dist;
	resp_t w_resp_code;

	assign w_reset   = i_reset;
	assign w_b_taken = o_axi_bvalid && i_axi_bready;

	assign w_next_first = i_accept ? r_first + 1'b1 : r_first;
	assign w_last_inc   = r_last + 1'b1;
	assign w_next_last  = w_b_taken ? w_last_inc : r_last;

	assign w_fill      = r_first - r_last;
	assign w_next_fill = w_next_first - w_next_last;

	////////////////////////////////////////////////////////////
	// Record pointers
	////////////////////////////////////////////////////////////

	// first counts accepts, mid counts bus replies, last counts B beats
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
		begin
			r_first <= '0;
			r_mid   <= '0;
			r_last  <= '0;
		end
		else
		begin
			r_first <= w_next_first;
			r_last  <= w_next_last;
			if (i_wb_done)
				r_mid <= r_mid + 1'b1;
			else if (o_err_state && (r_mid != r_first))
				r_mid <= r_mid + 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			o_full <= 1'b0;
		else
			o_full <= (w_next_fill == ptr_t'(FIFO_DEPTH));
	end

	////////////////////////////////////////////////////////////
	// Error state
	////////////////////////////////////////////////////////////

	// Slot of the write that failed on the bus
	always_ff @(posedge i_clk)
	begin
		if (i_wb_err)
			r_err_loc <= r_mid;
	end

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			o_err_state <= 1'b0;
		else if (r_first == r_last)
			o_err_state <= 1'b0;
		else if (i_wb_err)
			o_err_state <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// B channel
	////////////////////////////////////////////////////////////

	// Slot that the next B beat will carry
	assign w_resp_slot = o_axi_bvalid ? w_last_inc : r_last;
	assign w_err_dist  = w_resp_slot - r_err_loc;

	// Slots before the failing one already finished with OKAY
	always_comb
	begin
		w_resp_code = RESP_OKAY;
		if (o_err_state)
		begin
			if (w_resp_slot == r_err_loc)
				w_resp_code = RESP_SLVERR;
			else if (w_err_dist <= ptr_t'(FIFO_DEPTH))
				w_resp_code = RESP_DECERR;
		end
		else if (i_wb_err && (w_resp_slot == r_mid))
			w_resp_code = RESP_SLVERR;
	end

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			o_axi_bresp <= RESP_OKAY;
		else if (!o_axi_bvalid || i_axi_bready)
			o_axi_bresp <= w_resp_code;
	end

	// During the drain every accepted slot is answered, bus reply or not
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			o_axi_bvalid <= 1'b0;
		else if (i_wb_done)
			o_axi_bvalid <= 1'b1;
		else if (w_b_taken)
		begin
			if (o_err_state)
				o_axi_bvalid <= (w_last_inc != r_first);
			else
				o_axi_bvalid <= (w_last_inc != r_mid);
		end
	end

	a_full_depth: assert property (@(posedge i_clk) disable iff (w_reset)
		o_full == (w_fill == ptr_t'(FIFO_DEPTH)));

endmodule

// File: hdl/axilwr2wb_bridge.sv
/* Write-only bridge from an AXI-lite slave port to a pipelined Wishbone
   master port, built from the pairing, issue and response stages */
`timescale 1ns/1ps

module axilwr2wb_bridge
	import axil_bus_pkg::*;
	import wr_track_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	// AXI write address
	input  logic                  i_axi_awvalid,
	input  logic [AXI_ADDR_W-1:0] i_axi_awaddr,
	output logic                  o_axi_awready,
	// AXI write data
	input  logic                  i_axi_wvalid,
	input  data_t                 i_axi_wdata,
	input  sel_t                  i_axi_wstrb,
	output logic                  o_axi_wready,
	// AXI write response
	output logic                  o_axi_bvalid,
	output resp_t                 o_axi_bresp,
	input  logic                  i_axi_bready,
	// Wishbone requests
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output wb_addr_t              o_wb_addr,
	output data_t                 o_wb_data,
	output sel_t                  o_wb_sel,
	// Wishbone replies
	input  logic                  i_wb_ack,
	input  logic                  i_wb_stall,
	input  logic                  i_wb_err
);

	logic     w_reset;
	logic     w_issue_busy;
	logic     w_full;
	logic     w_err_state;
	logic     w_accept;
	wb_addr_t w_acc_addr;
	wr_data_t w_acc_data;
	logic     w_wb_done;
	logic     w_wb_err;

	assign w_reset = i_reset;

	axil_wr_pair u_axil_wr_pair (
		.i_clk         (i_clk),
		.i_reset       (w_reset),
		.i_axi_awvalid (i_axi_awvalid),
		.i_axi_awaddr  (i_axi_awaddr),
		.i_axi_wvalid  (i_axi_wvalid),
		.i_axi_wdata   (i_axi_wdata),
		.i_axi_wstrb   (i_axi_wstrb),
		.i_issue_busy  (w_issue_busy),
		.i_full        (w_full),
		.i_err_state   (w_err_state),
		.o_axi_awready (o_axi_awready),
		.o_axi_wready  (o_axi_wready),
		.o_accept      (w_accept),
		.o_acc_addr    (w_acc_addr),
		.o_acc_data    (w_acc_data)
	);

	wb_wr_issue u_wb_wr_issue (
		.i_clk        (i_clk),
		.i_reset      (w_reset),
		.i_accept     (w_accept),
		.i_acc_addr   (w_acc_addr),
		.i_acc_data   (w_acc_data),
		.i_wb_ack     (i_wb_ack),
		.i_wb_stall   (i_wb_stall),
		.i_wb_err     (i_wb_err),
		.i_err_state  (w_err_state),
		.o_wb_cyc     (o_wb_cyc),
		.o_wb_stb     (o_wb_stb),
		.o_wb_addr    (o_wb_addr),
		.o_wb_data    (o_wb_data),
		.o_wb_sel     (o_wb_sel),
		.o_issue_busy (w_issue_busy),
		.o_wb_done    (w_wb_done),
		.o_wb_err     (w_wb_err)
	);

	wr_resp_tracker u_wr_resp_tracker (
		.i_clk        (i_clk),
		.i_reset      (w_reset),
		.i_accept     (w_accept),
		.i_wb_done    (w_wb_done),
		.i_wb_err     (w_wb_err),
		.i_axi_bready (i_axi_bready),
		.o_axi_bvalid (o_axi_bvalid),
		.o_axi_bresp  (o_axi_bresp),
		.o_full       (w_full),
		.o_err_state  (w_err_state)
	);

endmodule

// File: dv/bridge_tb.sv
/* Testbench for the AXI-lite to Wishbone write bridge. Plays the writes of
   the vectors file, models an in-order Wishbone slave and checks B responses */
`timescale 1ns/1ps

module bridge_tb
	import axil_bus_pkg::*;
	import wr_track_pkg::*;
();

	localparam int CLK_HALF     = 10;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_VEC      = 64;
	localparam int FIELDS       = 8;
	localparam int ERR_DELAY    = 2;
	localparam int LONG_FIRST   = 24;
	localparam int WAIT_LIMIT   = 400;

	logic                  i_clk;
	logic                  i_reset;
	logic                  i_axi_awvalid;
	logic [AXI_ADDR_W-1:0] i_axi_awaddr;
	logic                  o_axi_awready;
	logic                  i_axi_wvalid;
	data_t                 i_axi_wdata;
	sel_t                  i_axi_wstrb;
	logic                  o_axi_wready;
	logic                  o_axi_bvalid;
	resp_t                 o_axi_bresp;
	logic                  i_axi_bready;
	logic                  o_wb_cyc;
	logic                  o_wb_stb;
	wb_addr_t              o_wb_addr;
	data_t                 o_wb_data;
	sel_t                  o_wb_sel;
	logic                  i_wb_ack;
	logic                  i_wb_stall;
	logic                  i_wb_err;

	logic [31:0]           vec_mem [FIELDS*MAX_VEC];
	logic [AXI_ADDR_W-1:0] v_addr  [MAX_VEC];
	data_t                 v_data  [MAX_VEC];
	sel_t                  v_strb  [MAX_VEC];
	int                    v_skew  [MAX_VEC];
	int                    v_stall [MAX_VEC];
	logic                  v_err   [MAX_VEC];
	int                    v_bhold [MAX_VEC];
	resp_t                 v_resp  [MAX_VEC];
	int                    n_vec;

	int          errors = 0;
	int          checks = 0;
	int          cyc_count = 0;
	int          wb_idx = 0;
	int          wb_ok_taken = 0;
	int          aw_cnt = 0;
	int          w_cnt = 0;
	int          b_cnt = 0;
	logic [31:0] lfsr = 32'hbcef;
	int          rep_idx [$];
	int          rep_due [$];

	axilwr2wb_bridge u_axilwr2wb_bridge (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_HALF) i_clk = ~i_clk;
	end

	always @(posedge i_clk)
		cyc_count <= cyc_count + 1;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	function automatic logic wb_matches(input int idx);
		return (o_wb_addr == (v_addr[idx] >> ADDR_LSBS))
			&& (o_wb_data == v_data[idx]) && (o_wb_sel == v_strb[idx]);
	endfunction

	// Writes answered with DECERR may never have reached the bus
	function automatic int find_vec(input int start);
		int i;
		i = start;
		while (i < n_vec && v_resp[i] == RESP_DECERR && !wb_matches(i))
			i++;
		return i;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			errors++;
			$display("error %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic load_vectors();
		int i;
		int b;
		for (i = 0; i < FIELDS*MAX_VEC; i++)
			vec_mem[i] = '1;
		$readmemh("dv/bridge_vectors.txt", vec_mem);
		n_vec = 0;
		while (n_vec < MAX_VEC && vec_mem[FIELDS*n_vec] != 32'hffff_ffff)
		begin
			b = FIELDS * n_vec;
			v_addr[n_vec]  = vec_mem[b][AXI_ADDR_W-1:0];
			v_data[n_vec]  = vec_mem[b+1];
			v_strb[n_vec]  = vec_mem[b+2][SEL_W-1:0];
			v_skew[n_vec]  = int'($signed(vec_mem[b+3][7:0]));
			v_stall[n_vec] = int'(vec_mem[b+4]);
			v_err[n_vec]   = vec_mem[b+5][0];
			v_bhold[n_vec] = int'(vec_mem[b+6]);
			v_resp[n_vec]  = vec_mem[b+7][1:0];
			n_vec++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// AXI write driver
	////////////////////////////////////////////////////////////

	task automatic drive_writes();
		int   i;
		int   c;
		int   aw_delay;
		int   w_delay;
		logic aw_pend;
		logic w_pend;
		logic aw_hs;
		logic w_hs;
		i = 0;
		c = 0;
		aw_pend = 1'b1;
		w_pend = 1'b1;
		aw_delay = (v_skew[0] < 0) ? -v_skew[0] : 0;
		w_delay = (v_skew[0] > 0) ? v_skew[0] : 0;
		while (i < n_vec)
		begin
			@(negedge i_clk);
			i_axi_awvalid = aw_pend && (c >= aw_delay);
			i_axi_awaddr = v_addr[i];
			i_axi_wvalid = w_pend && (c >= w_delay);
			i_axi_wdata = v_data[i];
			i_axi_wstrb = v_strb[i];
			#8;
			aw_hs = i_axi_awvalid && o_axi_awready;
			w_hs = i_axi_wvalid && o_axi_wready;
			@(posedge i_clk);
			if (aw_hs)
				aw_pend = 1'b0;
			if (w_hs)
				w_pend = 1'b0;
			c++;
			if (c > WAIT_LIMIT)
				abort_run($sformatf("AXI write %0d was never accepted", i));
			// Next write goes out on the very next falling edge
			if (!aw_pend && !w_pend)
			begin
				i++;
				c = 0;
				aw_pend = 1'b1;
				w_pend = 1'b1;
				if (i < n_vec)
				begin
					aw_delay = (v_skew[i] < 0) ? -v_skew[i] : 0;
					w_delay = (v_skew[i] > 0) ? v_skew[i] : 0;
				end
			end
		end
		@(negedge i_clk);
		i_axi_awvalid = 1'b0;
		i_axi_wvalid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// B channel collector
	////////////////////////////////////////////////////////////

	task automatic collect_responses();
		int   j;
		int   hold;
		int   c;
		logic took;
		for (j = 0; j < n_vec; j++)
		begin
			hold = v_bhold[j];
			c = 0;
			took = 1'b0;
			while (!took)
			begin
				@(negedge i_clk);
				i_axi_bready = (hold == 0);
				#8;
				took = o_axi_bvalid && i_axi_bready;
				if (took)
					compare_value($sformatf("bresp of write %0d", j), v_resp[j], o_axi_bresp);
				else if (o_axi_bvalid && hold > 0)
					hold--;
				@(posedge i_clk);
				c++;
				if (c > WAIT_LIMIT)
					abort_run($sformatf("no B response arrived for write %0d", j));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone slave model
	////////////////////////////////////////////////////////////

	initial
	begin : wishbone_slave
		int       idx;
		int       stall_left;
		logic     in_req;
		logic     prev_stalled;
		wb_addr_t prev_addr;
		data_t    prev_data;
		sel_t     prev_sel;
		in_req = 1'b0;
		stall_left = 0;
		prev_stalled = 1'b0;
		i_wb_ack = 1'b0;
		i_wb_stall = 1'b0;
		i_wb_err = 1'b0;
		forever
		begin
			@(negedge i_clk);
			i_wb_ack = 1'b0;
			i_wb_err = 1'b0;
			// Nothing is owed once the cycle has dropped
			if (!o_wb_cyc)
			begin
				rep_idx.delete();
				rep_due.delete();
			end
			if (rep_idx.size() > 0 && rep_due[0] <= cyc_count + 1)
			begin
				idx = rep_idx.pop_front();
				void'(rep_due.pop_front());
				if (v_err[idx])
				begin
					i_wb_err = 1'b1;
					rep_idx.delete();
					rep_due.delete();
				end
				else
					i_wb_ack = 1'b1;
			end
			if (!o_wb_stb)
				in_req = 1'b0;
			else if (!in_req)
			begin
				in_req = 1'b1;
				idx = find_vec(wb_idx);
				stall_left = (idx < n_vec) ? v_stall[idx] : 0;
				if (idx >= LONG_FIRST && idx < n_vec)
				begin
					stall_left += int'(lfsr[0]);
					lfsr = lfsr_step(lfsr);
					stall_left += int'(lfsr[0]);
					lfsr = lfsr_step(lfsr);
				end
			end
			i_wb_stall = (stall_left > 0);
			#8;
			if (o_wb_stb && prev_stalled)
			begin
				compare_value("wb_addr under stall", prev_addr, o_wb_addr);
				compare_value("wb_data under stall", prev_data, o_wb_data);
				compare_value("wb_sel under stall", prev_sel, o_wb_sel);
			end
			prev_stalled = o_wb_stb && i_wb_stall;
			prev_addr = o_wb_addr;
			prev_data = o_wb_data;
			prev_sel = o_wb_sel;
			if (o_wb_stb && !i_wb_stall)
			begin
				idx = find_vec(wb_idx);
				checks++;
				assert (idx < n_vec)
				else
				begin
					errors++;
					$display("Wishbone took a write that matches no pending AXI write");
				end
				if (idx < n_vec)
				begin
					compare_value($sformatf("wb_addr of write %0d", idx),
						v_addr[idx] >> ADDR_LSBS, o_wb_addr);
					compare_value($sformatf("wb_data of write %0d", idx), v_data[idx], o_wb_data);
					compare_value($sformatf("wb_sel of write %0d", idx), v_strb[idx], o_wb_sel);
					if (v_resp[idx] != RESP_DECERR)
						wb_ok_taken++;
					rep_idx.push_back(idx);
					rep_due.push_back(cyc_count + 2 + (v_err[idx] ? ERR_DELAY : 0));
				end
				wb_idx = idx + 1;
				in_req = 1'b0;
			end
			else if (o_wb_stb)
				stall_left--;
		end
	end

	// Writes in flight on the AXI side never exceed the record depth
	initial
	begin : capacity_monitor
		forever
		begin
			@(negedge i_clk);
			#8;
			if (i_axi_awvalid && o_axi_awready)
				aw_cnt++;
			if (i_axi_wvalid && o_axi_wready)
				w_cnt++;
			if (o_axi_bvalid && i_axi_bready)
				b_cnt++;
			assert (aw_cnt - b_cnt <= FIFO_DEPTH && w_cnt - b_cnt <= FIFO_DEPTH)
			else
			begin
				errors++;
				$display("more writes were accepted than the record can hold");
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int n_ok;
		int k;
		i_reset = 1'b1;
		i_axi_awvalid = 1'b0;
		i_axi_awaddr = '0;
		i_axi_wvalid = 1'b0;
		i_axi_wdata = '0;
		i_axi_wstrb = '0;
		i_axi_bready = 1'b0;
		load_vectors();
		if (n_vec == 0)
			abort_run("the vectors file held no writes");
		repeat (RESET_CYCLES) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;
		#8;
		compare_value("awready after reset", 1, o_axi_awready);
		compare_value("wready after reset", 1, o_axi_wready);
		compare_value("wb_cyc after reset", 0, o_wb_cyc);
		compare_value("wb_stb after reset", 0, o_wb_stb);
		compare_value("bvalid after reset", 0, o_axi_bvalid);
		compare_value("bresp after reset", 0, o_axi_bresp);

		fork
			drive_writes();
			collect_responses();
		join

		// No stray responses or bus requests afterwards
		for (k = 0; k < 10; k++)
		begin
			@(negedge i_clk);
			#8;
			compare_value("late bvalid", 0, o_axi_bvalid);
			compare_value("late wb_stb", 0, o_wb_stb);
			compare_value("late wb_cyc", 0, o_wb_cyc);
		end

		n_ok = 0;
		for (k = 0; k < n_vec; k++)
			if (v_resp[k] != RESP_DECERR)
				n_ok++;
		compare_value("Wishbone write count", n_ok, wb_ok_taken);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: all.f
hdl/axil_bus_pkg.sv
hdl/wr_track_pkg.sv
hdl/axil_hold_slot.sv
hdl/axil_wr_pair.sv
hdl/wb_wr_issue.sv
hdl/wr_resp_tracker.sv
hdl/axilwr2wb_bridge.sv
dv/bridge_tb.sv

// File: Makefile
# Verilator simulation of the AXI-lite to Wishbone write bridge

VERILATOR ?= verilator
TOP       ?= bridge_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || \
		{ echo "simulation ended without a result line"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/bridge_vectors.txt
// addr    data     strb skew stall err bhold resp  (all hex, one write per line)
// skew is a signed byte in cycles, positive means the address leads the data
// Pairing orders
0000100 11111111 f 00 0 0 00 0
0000204 22222222 3 03 0 0 00 0
0000308 33333333 c fd 0 0 00 0
000040c 44444444 f 00 0 0 02 0
// Wishbone stall
0001000 55555555 f 00 3 0 00 0
0001004 66666666 1 01 5 0 00 0
0001008 77777777 8 ff 2 0 00 0
// B back-pressure, ten writes behind a held response
0002000 a0000000 f 00 0 0 18 0
0002004 a0000001 f 00 0 0 00 0
0002008 a0000002 f 00 0 0 00 0
000200c a0000003 f 00 0 0 00 0
0002010 a0000004 f 00 0 0 00 0
0002014 a0000005 f 00 0 0 00 0
0002018 a0000006 f 00 0 0 00 0
000201c a0000007 f 00 0 0 00 0
0002020 a0000008 f 00 0 0 00 0
0002024 a0000009 f 00 0 0 00 0
// Slow spacer, then a bus error, the writes caught in the drain, and one after it
0003000 c0000000 f 20 0 0 00 0
0003004 e0000000 f 00 0 1 00 2
0003008 e0000001 f 00 0 0 00 3
000300c e0000002 f 00 0 0 00 3
0003010 e0000003 f 00 0 0 00 3
0003014 e0000004 f 00 0 0 00 3
0003018 e0000005 f 00 0 0 00 0
// Long run with extra random stall
0004000 0badf00d 5 02 1 0 01 0
0004004 deadbeef f fe 0 0 00 0
0004008 12345678 a 00 2 0 00 0
000400c 87654321 f 01 0 0 03 0
0004010 cafe0123 6 00 1 0 00 0
